// File: sources.f
src/io_pkg.sv
src/io_sync.sv
src/io_decoder.sv
src/gpio_regs.sv
src/clint_timer.sv
src/io_platform.sv
sim/io_platform_sva.sv
sim/io_platform_tb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := io_platform_tb
FILELIST := sources.f
BUILD    := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the simulation, fail unless it passes"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o $(TOP)
	@out="$$(./$(BUILD)/$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf $(BUILD)

// File: sim/io_platform_tb.sv
//////////////////////////////////////////////////
// IO subsystem testbench with bus tasks and GPIO,
// error, interrupt, timer and back-pressure checks
//////////////////////////////////////////////////

`timescale 1ns/100ps

module io_platform_tb;

    localparam int SYNC_STAGES = 2;
    localparam int TIMEOUT     = 50;

    localparam io_pkg::addr_t ADDR_GPIO_OUT = io_pkg::GPIO_BASE + io_pkg::GPIO_OUT_OFS;
    localparam io_pkg::addr_t ADDR_GPIO_IN  = io_pkg::GPIO_BASE + io_pkg::GPIO_IN_OFS;
    localparam io_pkg::addr_t ADDR_MSIP     = io_pkg::CLINT_BASE + io_pkg::CLINT_MSIP_OFS;
    localparam io_pkg::addr_t ADDR_CMP_LO   = io_pkg::CLINT_BASE + io_pkg::CLINT_CMP_LO_OFS;
    localparam io_pkg::addr_t ADDR_CMP_HI   = io_pkg::CLINT_BASE + io_pkg::CLINT_CMP_HI_OFS;
    localparam io_pkg::addr_t ADDR_TIME_LO  = io_pkg::CLINT_BASE + io_pkg::CLINT_TIME_LO_OFS;
    localparam io_pkg::addr_t ADDR_TIME_HI  = io_pkg::CLINT_BASE + io_pkg::CLINT_TIME_HI_OFS;

    logic             aclk;
    logic             arst_n;
    logic             req_valid;
    logic             req_ready;
    logic             req_write;
    io_pkg::addr_t    req_addr;
    io_pkg::word_t    req_wdata;
    io_pkg::strb_t    req_wstrb;
    logic             rsp_valid;
    logic             rsp_ready;
    io_pkg::word_t    rsp_rdata;
    io_pkg::io_resp_t rsp_resp;
    logic             rtc;
    io_pkg::word_t    gpio_in;
    io_pkg::word_t    gpio_out;
    logic             sw_irq;
    logic             timer_irq;

    int          checks;
    int          errors;
    int          timeouts;
    logic [31:0] seed;

    io_platform #(
        .SYNC_STAGES (SYNC_STAGES)
    ) dut (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .req_wstrb (req_wstrb),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_rdata (rsp_rdata),
        .rsp_resp  (rsp_resp),
        .rtc       (rtc),
        .gpio_in   (gpio_in),
        .gpio_out  (gpio_out),
        .sw_irq    (sw_irq),
        .timer_irq (timer_irq)
    );

    always #2 aclk = ~aclk;

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Bit mask of the bytes selected by the strobes
    function automatic io_pkg::word_t strb_mask(io_pkg::strb_t s);
        io_pkg::word_t m;
        for (int b = 0; b < io_pkg::XLEN / 8; b++) begin
            m[8*b +: 8] = {8{s[b]}};
        end
        return m;
    endfunction

    task automatic verify_word(input io_pkg::word_t got, input io_pkg::word_t exp,
                               input string what);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERR %0t ns: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Single access with rsp_ready held low for hold cycles
    task automatic access(input logic wr, input io_pkg::addr_t addr, input io_pkg::word_t data,
                          input io_pkg::strb_t strb, input int hold,
                          output io_pkg::word_t rdata, output io_pkg::io_resp_t resp);
        int            t;
        io_pkg::word_t held;
        rdata = '0;
        resp  = io_pkg::OKAY;
        t = 0;
        while (!req_ready && t < TIMEOUT) begin
            @(negedge aclk);
            t++;
        end
        if (!req_ready) begin
            timeouts++;
            $display("Timeout at %0t ns: req_ready never came back high", $time);
        end
        req_valid = 1'b1;
        req_write = wr;
        req_addr  = addr;
        req_wdata = data;
        req_wstrb = strb;
        @(negedge aclk);
        req_valid = 1'b0;
        t = 0;
        while (!rsp_valid && t < TIMEOUT) begin
            @(negedge aclk);
            t++;
        end
        if (!rsp_valid) begin
            timeouts++;
            $display("Timeout at %0t ns: no response for address %h", $time, addr);
            return;
        end
        held = rsp_rdata;
        for (int i = 0; i < hold; i++) begin
            @(negedge aclk);
            verify_word(32'(req_ready), 32'd0, "req_ready under back-pressure");
            verify_word(rsp_rdata, held, "rsp_rdata under back-pressure");
        end
        rsp_ready = 1'b1;
        rdata     = rsp_rdata;
        resp      = rsp_resp;
        t = 0;
        do begin
            @(negedge aclk);
            t++;
        end while (rsp_valid && t < TIMEOUT);
        rsp_ready = 1'b0;
        if (rsp_valid) begin
            timeouts++;
            $display("Timeout at %0t ns: rsp_valid stayed high after handshake", $time);
        end
    endtask

    task automatic write_word(input io_pkg::addr_t addr, input io_pkg::word_t data,
                              input io_pkg::strb_t strb, input io_pkg::io_resp_t exp_resp,
                              input int hold);
        io_pkg::word_t    got;
        io_pkg::io_resp_t resp;
        access(1'b1, addr, data, strb, hold, got, resp);
        verify_word(got, '0, $sformatf("write data at %h", addr));
        verify_word(32'(resp), 32'(exp_resp), $sformatf("write response at %h", addr));
    endtask

    task automatic read_word(input io_pkg::addr_t addr, input io_pkg::word_t exp_data,
                             input io_pkg::io_resp_t exp_resp, input int hold);
        io_pkg::word_t    got;
        io_pkg::io_resp_t resp;
        access(1'b0, addr, '0, '0, hold, got, resp);
        verify_word(got, exp_data, $sformatf("read data at %h", addr));
        verify_word(32'(resp), 32'(exp_resp), $sformatf("read response at %h", addr));
    endtask

    task automatic pulse_rtc();
        rtc = 1'b1;
        repeat (4) @(negedge aclk);
        rtc = 1'b0;
        repeat (4) @(negedge aclk);
    endtask

    // Interrupt register follows a compare change within two cycles
    task automatic await_timer_irq(input logic level);
        int t;
        t = 0;
        while (timer_irq !== level && t < 2) begin
            @(negedge aclk);
            t++;
        end
        verify_word(32'(timer_irq), 32'(level), "timer_irq after compare write");
    endtask

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    initial begin
        io_pkg::word_t exp_out;
        io_pkg::word_t exp_in;
        io_pkg::word_t data;
        io_pkg::word_t mask;
        logic [31:0]   r;
        int            n;
        int            hold;
        aclk      = 1'b0;
        arst_n    = 1'b0;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        req_wstrb = '0;
        rsp_ready = 1'b0;
        rtc       = 1'b0;
        gpio_in   = '0;
        checks    = 0;
        errors    = 0;
        timeouts  = 0;
        seed      = 32'hde01;
        repeat (2) @(negedge aclk);
        arst_n = 1'b1;

        // Reset state
        verify_word(32'(req_ready), 32'd1, "req_ready after reset");
        verify_word(32'(rsp_valid | sw_irq | timer_irq), 32'd0, "outputs after reset");
        verify_word(gpio_out, '0, "gpio_out after reset");
        read_word(ADDR_CMP_LO, '1, io_pkg::OKAY, 0);
        read_word(ADDR_CMP_HI, '1, io_pkg::OKAY, 0);
        read_word(ADDR_TIME_LO, '0, io_pkg::OKAY, 0);

        // GPIO output under random strobes
        exp_out = '0;
        for (int k = 0; k < 4; k++) begin
            data = next_rand();
            r    = next_rand();
            mask = strb_mask(r[3:0]);
            exp_out = (exp_out & ~mask) | (data & mask);
            write_word(ADDR_GPIO_OUT, data, r[3:0], io_pkg::OKAY, 0);
            verify_word(gpio_out, exp_out, "gpio_out after write");
            read_word(ADDR_GPIO_OUT, exp_out, io_pkg::OKAY, 0);
        end

        // GPIO input through the synchronizer
        exp_in  = next_rand();
        gpio_in = exp_in;
        repeat (SYNC_STAGES + 1) @(negedge aclk);
        read_word(ADDR_GPIO_IN, exp_in, io_pkg::OKAY, 0);

        // Error responses leave the registers alone
        write_word(ADDR_GPIO_IN, next_rand(), 4'hf, io_pkg::SLVERR, 0);
        write_word(8'h0c, next_rand(), 4'hf, io_pkg::DECERR, 0);
        read_word(8'h14, '0, io_pkg::DECERR, 0);
        write_word(8'h2c, next_rand(), 4'hf, io_pkg::DECERR, 0);
        read_word(8'hf0, '0, io_pkg::DECERR, 0);
        read_word(ADDR_GPIO_OUT, exp_out, io_pkg::OKAY, 0);
        read_word(ADDR_GPIO_IN, exp_in, io_pkg::OKAY, 0);
        read_word(ADDR_CMP_LO, '1, io_pkg::OKAY, 0);
        verify_word(gpio_out, exp_out, "gpio_out after error writes");

        // Software interrupt
        write_word(ADDR_MSIP, 32'd1, 4'hf, io_pkg::OKAY, 0);
        verify_word(32'(sw_irq), 32'd1, "sw_irq after set");
        read_word(ADDR_MSIP, 32'd1, io_pkg::OKAY, 0);
        write_word(ADDR_MSIP, 32'd0, 4'hf, io_pkg::OKAY, 0);
        verify_word(32'(sw_irq), 32'd0, "sw_irq after clear");

        // Timer load, then ticks and compare
        data = next_rand();
        write_word(ADDR_TIME_LO, data, 4'hf, io_pkg::OKAY, 0);
        read_word(ADDR_TIME_LO, data, io_pkg::OKAY, 0);
        data = next_rand();
        write_word(ADDR_TIME_HI, data, 4'hf, io_pkg::OKAY, 0);
        read_word(ADDR_TIME_HI, data, io_pkg::OKAY, 0);
        write_word(ADDR_TIME_LO, '0, 4'hf, io_pkg::OKAY, 0);
        write_word(ADDR_TIME_HI, '0, 4'hf, io_pkg::OKAY, 0);
        r = next_rand();
        n = 3 + int'(r[1:0]);
        for (int k = 0; k < n; k++) begin
            pulse_rtc();
        end
        read_word(ADDR_TIME_LO, 32'(n), io_pkg::OKAY, 0);
        read_word(ADDR_TIME_HI, '0, io_pkg::OKAY, 0);
        write_word(ADDR_CMP_HI, '0, 4'hf, io_pkg::OKAY, 0);
        await_timer_irq(1'b0);
        write_word(ADDR_CMP_LO, 32'(n), 4'hf, io_pkg::OKAY, 0);
        await_timer_irq(1'b1);
        r = next_rand();
        write_word(ADDR_CMP_LO, 32'(n + 1 + int'(r[2:0])), 4'hf, io_pkg::OKAY, 0);
        await_timer_irq(1'b0);

        // Back-pressure on reads and a write
        exp_out = next_rand();
        r = next_rand();
        hold = 2 + int'(r[2:0]);
        write_word(ADDR_GPIO_OUT, exp_out, 4'hf, io_pkg::OKAY, hold);
        r = next_rand();
        hold = 2 + int'(r[2:0]);
        read_word(ADDR_GPIO_OUT, exp_out, io_pkg::OKAY, hold);
        r = next_rand();
        hold = 2 + int'(r[2:0]);
        read_word(ADDR_TIME_LO, 32'(n), io_pkg::OKAY, hold);

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: sim/io_platform_sva.sv
//////////////////////////////////////////////////
// Register port protocol assertions
//////////////////////////////////////////////////

`timescale 1ns/100ps

module io_platform_sva (
    input logic             aclk,
    input logic             arst_n,
    input logic             req_valid,
    input logic             req_ready,
    input logic             rsp_valid,
    input logic             rsp_ready,
    input io_pkg::word_t    rsp_rdata,
    input io_pkg::io_resp_t rsp_resp,
    input logic             sw_irq,
    input logic             timer_irq
);

    // No new request while a response is outstanding
    ready_vs_response: assert property (@(posedge aclk) disable iff (!arst_n)
        !(rsp_valid && req_ready))
        else $error("req_ready high while a response is pending");

    // Stalled response holds its data and code
    response_held: assert property (@(posedge aclk) disable iff (!arst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rdata) && $stable(rsp_resp))
        else $error("response changed under back-pressure");

    response_after_accept: assert property (@(posedge aclk) disable iff (!arst_n)
        req_valid && req_ready |=> $rose(rsp_valid))
        else $error("rsp_valid did not rise one cycle after acceptance");

    response_needs_accept: assert property (@(posedge aclk) disable iff (!arst_n)
        $rose(rsp_valid) |-> $past(req_valid && req_ready))
        else $error("rsp_valid rose without an accepted request");

    quiet_in_reset: assert property (@(posedge aclk)
        !arst_n |-> !rsp_valid && !sw_irq && !timer_irq)
        else $error("response or interrupt high during reset");

endmodule

bind io_platform io_platform_sva u_sva (
    .aclk      (aclk),
    .arst_n    (arst_n),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp_rdata (rsp_rdata),
    .rsp_resp  (rsp_resp),
    .sw_irq    (sw_irq),
    .timer_irq (timer_irq)
);

// File: src/io_platform.sv
//////////////////////////////////////////////////
// IO subsystem top: decoder, synchronizers,
// GPIO and CLINT
//////////////////////////////////////////////////

`timescale 1ns/100ps

module io_platform #(
    parameter int SYNC_STAGES = 2
) (
    input  logic             aclk,
    input  logic             arst_n,
    // Request channel
    input  logic             req_valid,
    output logic             req_ready,
    input  logic             req_write,
    input  io_pkg::addr_t    req_addr,
    input  io_pkg::word_t    req_wdata,
    input  io_pkg::strb_t    req_wstrb,
    // Response channel
    output logic             rsp_valid,
    input  logic             rsp_ready,
    output io_pkg::word_t    rsp_rdata,
    output io_pkg::io_resp_t rsp_resp,
    // Pins and interrupts
    input  logic             rtc,
    input  io_pkg::word_t    gpio_in,
    output io_pkg::word_t    gpio_out,
    output logic             sw_irq,
    output logic             timer_irq
);

    logic          gpio_we;
    logic          clint_we;
    io_pkg::addr_t ofs;
    io_pkg::word_t wdata;
    io_pkg::strb_t wstrb;
    io_pkg::word_t gpio_rdata;
    logic          gpio_err;
    io_pkg::word_t clint_rdata;
    io_pkg::word_t gpio_in_sync;
    logic          rtc_sync;

    //////////////////////////////////////////////////
    // Register port
    //////////////////////////////////////////////////

    io_decoder u_decoder (
        .aclk        (aclk),
        .arst_n      (arst_n),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .req_write   (req_write),
        .req_addr    (req_addr),
        .req_wdata   (req_wdata),
        .req_wstrb   (req_wstrb),
        .rsp_valid   (rsp_valid),
        .rsp_ready   (rsp_ready),
        .rsp_rdata   (rsp_rdata),
        .rsp_resp    (rsp_resp),
        .gpio_we     (gpio_we),
        .clint_we    (clint_we),
        .ofs         (ofs),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .gpio_rdata  (gpio_rdata),
        .gpio_err    (gpio_err),
        .clint_rdata (clint_rdata)
    );

    //////////////////////////////////////////////////
    // Input synchronizers
    //////////////////////////////////////////////////

    io_sync #(
        .SYNC_STAGES (SYNC_STAGES),
        .data_t      (io_pkg::word_t)
    ) u_gpio_sync (
        .aclk     (aclk),
        .arst_n   (arst_n),
        .async_in (gpio_in),
        .sync_out (gpio_in_sync)
    );

    io_sync #(
        .SYNC_STAGES (SYNC_STAGES),
        .data_t      (logic)
    ) u_rtc_sync (
        .aclk     (aclk),
        .arst_n   (arst_n),
        .async_in (rtc),
        .sync_out (rtc_sync)
    );

    //////////////////////////////////////////////////
    // Register windows
    //////////////////////////////////////////////////

    gpio_regs u_gpio (
        .aclk     (aclk),
        .arst_n   (arst_n),
        .we       (gpio_we),
        .ofs      (ofs),
        .wdata    (wdata),
        .wstrb    (wstrb),
        .pins_in  (gpio_in_sync),
        .rdata    (gpio_rdata),
        .err      (gpio_err),
        .pins_out (gpio_out)
    );

    clint_timer u_clint (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .we        (clint_we),
        .ofs       (ofs),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .rtc_sync  (rtc_sync),
        .rdata     (clint_rdata),
        .sw_irq    (sw_irq),
        .timer_irq (timer_irq)
    );

endmodule

// File: src/clint_timer.sv
//////////////////////////////////////////////////
// CLINT: rtc driven machine timer, compare and
// software interrupt registers
//////////////////////////////////////////////////

`timescale 1ns/100ps

module clint_timer (
    input  logic          aclk,
    input  logic          arst_n,
    input  logic          we,
    input  io_pkg::addr_t ofs,
    input  io_pkg::word_t wdata,
    input  io_pkg::strb_t wstrb,
    input  logic          rtc_sync,
    output io_pkg::word_t rdata,
    output logic          sw_irq,
    output logic          timer_irq
);

    localparam int XLEN = io_pkg::XLEN;

    logic                rtc_q;
    logic                rtc_rise;
    logic [2*XLEN-1:0]   mtime;
    logic [2*XLEN-1:0]   mtimecmp;
    logic                msip;
    logic                msip_we;
    logic                cmp_lo_we;
    logic                cmp_hi_we;
    logic                time_lo_we;
    logic                time_hi_we;

    assign msip_we    = we & (ofs == io_pkg::CLINT_MSIP_OFS);
    assign cmp_lo_we  = we & (ofs == io_pkg::CLINT_CMP_LO_OFS);
    assign cmp_hi_we  = we & (ofs == io_pkg::CLINT_CMP_HI_OFS);
    assign time_lo_we = we & (ofs == io_pkg::CLINT_TIME_LO_OFS);
    assign time_hi_we = we & (ofs == io_pkg::CLINT_TIME_HI_OFS);

    //////////////////////////////////////////////////
    // Real-time clock edge and machine timer
    //////////////////////////////////////////////////

    assign rtc_rise = rtc_sync & ~rtc_q;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            rtc_q <= 1'b0;
        end else begin
            rtc_q <= rtc_sync;
        end
    end

    // Software writes win over the tick
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            mtime <= '0;
        end else if (time_lo_we) begin
            mtime[XLEN-1:0] <= io_pkg::apply_strb(mtime[XLEN-1:0], wdata, wstrb);
        end else if (time_hi_we) begin
            mtime[2*XLEN-1:XLEN] <= io_pkg::apply_strb(mtime[2*XLEN-1:XLEN], wdata, wstrb);
        end else if (rtc_rise) begin
            mtime <= mtime + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Compare and software interrupt
    //////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            mtimecmp <= '1;
        end else if (cmp_lo_we) begin
            mtimecmp[XLEN-1:0] <= io_pkg::apply_strb(mtimecmp[XLEN-1:0], wdata, wstrb);
        end else if (cmp_hi_we) begin
            mtimecmp[2*XLEN-1:XLEN] <=
                io_pkg::apply_strb(mtimecmp[2*XLEN-1:XLEN], wdata, wstrb);
        end
    end

    // Only bit 0 of the msip word is implemented
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            msip <= 1'b0;
        end else if (msip_we && wstrb[0]) begin
            msip <= wdata[0];
        end
    end

    // Compare registered, follows a change by one cycle
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            timer_irq <= 1'b0;
        end else begin
            timer_irq <= (mtime >= mtimecmp);
        end
    end

    assign sw_irq = msip;

    always_comb begin
        case (ofs)
            io_pkg::CLINT_MSIP_OFS:    rdata = {{(XLEN-1){1'b0}}, msip};
            io_pkg::CLINT_CMP_LO_OFS:  rdata = mtimecmp[XLEN-1:0];
            io_pkg::CLINT_CMP_HI_OFS:  rdata = mtimecmp[2*XLEN-1:XLEN];
            io_pkg::CLINT_TIME_LO_OFS: rdata = mtime[XLEN-1:0];
            io_pkg::CLINT_TIME_HI_OFS: rdata = mtime[2*XLEN-1:XLEN];
            default:                   rdata = '0;
        endcase
    end

endmodule

// File: src/gpio_regs.sv
//////////////////////////////////////////////////
// GPIO output register and input readback
//////////////////////////////////////////////////

`timescale 1ns/100ps

module gpio_regs (
    input  logic          aclk,
    input  logic          arst_n,
    input  logic          we,
    input  io_pkg::addr_t ofs,
    input  io_pkg::word_t wdata,
    input  io_pkg::strb_t wstrb,
    input  io_pkg::word_t pins_in,
    output io_pkg::word_t rdata,
    output logic          err,
    output io_pkg::word_t pins_out
);

    io_pkg::word_t out_q;
    logic          out_we;

    assign out_we = we & (ofs == io_pkg::GPIO_OUT_OFS);

    // Input word is read only
    assign err = we & (ofs == io_pkg::GPIO_IN_OFS);

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            out_q <= '0;
        end else if (out_we) begin
            out_q <= io_pkg::apply_strb(out_q, wdata, wstrb);
        end
    end

    assign pins_out = out_q;

    always_comb begin
        case (ofs)
            io_pkg::GPIO_OUT_OFS: rdata = out_q;
            io_pkg::GPIO_IN_OFS:  rdata = pins_in;
            default:              rdata = '0;
        endcase
    end

endmodule

// File: src/io_decoder.sv
//////////////////////////////////////////////////
// Request control, window decode, response
// capture and back-pressure of the IO port
//////////////////////////////////////////////////

`timescale 1ns/100ps

module io_decoder (
    input  logic             aclk,
    input  logic             arst_n,
    // Request channel
    input  logic             req_valid,
    output logic             req_ready,
    input  logic             req_write,
    input  io_pkg::addr_t    req_addr,
    input  io_pkg::word_t    req_wdata,
    input  io_pkg::strb_t    req_wstrb,
    // Response channel
    output logic             rsp_valid,
    input  logic             rsp_ready,
    output io_pkg::word_t    rsp_rdata,
    output io_pkg::io_resp_t rsp_resp,
    // Window side
    output logic             gpio_we,
    output logic             clint_we,
    output io_pkg::addr_t    ofs,
    output io_pkg::word_t    wdata,
    output io_pkg::strb_t    wstrb,
    input  io_pkg::word_t    gpio_rdata,
    input  logic             gpio_err,
    input  io_pkg::word_t    clint_rdata
);

    logic             pending;
    logic             accept;
    io_pkg::io_sel_t  sel;
    io_pkg::addr_t    gpio_rel;
    io_pkg::addr_t    uart_rel;
    io_pkg::addr_t    clint_rel;
    io_pkg::word_t    rdata_d;
    io_pkg::io_resp_t resp_d;

    //////////////////////////////////////////////////
    // Address decode
    //////////////////////////////////////////////////

    // Below-base addresses wrap and fail the size test
    assign gpio_rel  = req_addr - io_pkg::GPIO_BASE;
    assign uart_rel  = req_addr - io_pkg::UART_BASE;
    assign clint_rel = req_addr - io_pkg::CLINT_BASE;

    always_comb begin
        if (gpio_rel < io_pkg::GPIO_SIZE) begin
            sel = io_pkg::SEL_GPIO;
        end else if (uart_rel < io_pkg::UART_SIZE) begin
            // UART hole, no target
            sel = io_pkg::SEL_NONE;
        end else if (clint_rel < io_pkg::CLINT_SIZE) begin
            sel = io_pkg::SEL_CLINT;
        end else begin
            sel = io_pkg::SEL_NONE;
        end
    end

    // Word offset inside the window, byte lanes dropped
    always_comb begin
        case (sel)
            io_pkg::SEL_GPIO:  ofs = {gpio_rel[io_pkg::IO_ADDR_W-1:2], 2'b00};
            io_pkg::SEL_CLINT: ofs = {clint_rel[io_pkg::IO_ADDR_W-1:2], 2'b00};
            default:           ofs = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // Handshake and write strobes
    //////////////////////////////////////////////////

    assign req_ready = ~pending;
    assign rsp_valid = pending;
    assign accept    = req_valid & ~pending;

    assign gpio_we  = accept & req_write & (sel == io_pkg::SEL_GPIO);
    assign clint_we = accept & req_write & (sel == io_pkg::SEL_CLINT);
    assign wdata    = req_wdata;
    assign wstrb    = req_wstrb;

    // Response word and code for the current request
    always_comb begin
        rdata_d = '0;
        resp_d  = io_pkg::OKAY;
        case (sel)
            io_pkg::SEL_GPIO: begin
                if (gpio_err) begin
                    resp_d = io_pkg::SLVERR;
                end else if (!req_write) begin
                    rdata_d = gpio_rdata;
                end
            end
            io_pkg::SEL_CLINT: begin
                if (!req_write) begin
                    rdata_d = clint_rdata;
                end
            end
            default: resp_d = io_pkg::DECERR;
        endcase
    end

    // One access in flight, cleared by the response handshake
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            pending <= 1'b0;
        end else if (accept) begin
            pending <= 1'b1;
        end else if (pending && rsp_ready) begin
            pending <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            rsp_rdata <= rdata_d;
            rsp_resp  <= resp_d;
        end
    end

endmodule

// File: src/io_sync.sv
//////////////////////////////////////////////////
// Multi-stage synchronizer, generic payload
//////////////////////////////////////////////////

`timescale 1ns/100ps

module io_sync #(
    parameter int  SYNC_STAGES = 2,
    parameter type data_t      = logic
) (
    input  logic  aclk,
    input  logic  arst_n,
    input  data_t async_in,
    output data_t sync_out
);

    // Stage 0 samples the asynchronous input
    data_t stages [SYNC_STAGES];

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < SYNC_STAGES; i++) begin
                stages[i] <= '0;
            end
        end else begin
            stages[0] <= async_in;
            for (int i = 1; i < SYNC_STAGES; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    assign sync_out = stages[SYNC_STAGES-1];

endmodule

// File: src/io_pkg.sv
//////////////////////////////////////////////////
// IO subsystem widths, address map, register
// offsets, response codes and byte strobe merge
//////////////////////////////////////////////////

package io_pkg;

    // Data and address widths
    localparam int XLEN      = 32;
    localparam int IO_ADDR_W = 8;

    typedef logic [XLEN-1:0]      word_t;
    typedef logic [IO_ADDR_W-1:0] addr_t;
    typedef logic [XLEN/8-1:0]    strb_t;

    //////////////////////////////////////////////////
    // Memory map of the IO window
    //////////////////////////////////////////////////

    localparam addr_t GPIO_BASE  = 8'h00;
    localparam addr_t GPIO_SIZE  = 8'd8;
    // UART window is left unmapped
    localparam addr_t UART_BASE  = 8'h08;
    localparam addr_t UART_SIZE  = 8'd16;
    localparam addr_t CLINT_BASE = 8'h18;
    localparam addr_t CLINT_SIZE = 8'd20;

    // GPIO word offsets
    localparam addr_t GPIO_OUT_OFS = 8'h00;
    localparam addr_t GPIO_IN_OFS  = 8'h04;

    // CLINT word offsets
    localparam addr_t CLINT_MSIP_OFS    = 8'h00;
    localparam addr_t CLINT_CMP_LO_OFS  = 8'h04;
    localparam addr_t CLINT_CMP_HI_OFS  = 8'h08;
    localparam addr_t CLINT_TIME_LO_OFS = 8'h0c;
    localparam addr_t CLINT_TIME_HI_OFS = 8'h10;

    // Same coding as the AXI response field
    typedef enum logic [1:0] {
        OKAY   = 2'd0,
        SLVERR = 2'd2,
        DECERR = 2'd3
    } io_resp_t;

    typedef enum logic [1:0] {
        SEL_NONE,
        SEL_GPIO,
        SEL_CLINT
    } io_sel_t;

    // Replace the strobed bytes of a word
    function automatic word_t apply_strb(word_t cur, word_t data, strb_t strb);
        word_t res;
        res = cur;
        for (int i = 0; i < XLEN/8; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = data[8*i +: 8];
            end
        end
        return res;
    endfunction

endpackage
